/* compile.f */
+incdir+logic
logic/ahb_mem_pkg.sv
logic/ahb_slave_if.sv
logic/ahb_addr_decode.sv
logic/ahb_sram_bank.sv
logic/ahb_default_slave.sv
logic/ahb_slave_mux.sv
logic/ahb_mem_top.sv
verif/ahb_mem_tb.sv

/* verif/ahb_mem_cases.txt */
// op addr size wdata rdata resp, all hex; op 0 idle, 1 read, 2 write
// size 0 byte, 1 half, 2 word; resp 1 = ERROR; rdata checked on reads
// One word per bank, read back from each buffer
2 00000010 2 11111111 00000000 0
2 00000410 2 22222222 00000000 0
2 00000810 2 33333333 00000000 0
1 00000010 2 00000000 11111111 0
1 00000410 2 00000000 22222222 0
1 00000810 2 00000000 33333333 0
// Second write in bank 0 pushes the first to the array
2 00000020 2 44444444 00000000 0
1 00000010 2 00000000 11111111 0
1 00000020 2 00000000 44444444 0
// Byte and halfword merge in bank 2
2 00000840 2 a5a5a5a5 00000000 0
2 00000840 0 000000c3 00000000 0
2 00000843 0 7e000000 00000000 0
2 00000842 1 9d6b0000 00000000 0
1 00000840 2 00000000 9d6ba5c3 0
2 00000840 1 0000e10f 00000000 0
1 00000841 0 00000000 9d6be10f 0
// Read right behind a write to the same word
2 00000104 2 cafef00d 00000000 0
1 00000104 2 00000000 cafef00d 0
// Idle cycles, one of them to an unmapped address
0 00000000 2 00000000 00000000 0
0 00000c00 2 00000000 00000000 0
1 00000020 2 00000000 44444444 0
// Unmapped transfers, beyond the last bank and with upper bits set
1 00000c00 2 00000000 00000000 1
1 00000104 2 00000000 cafef00d 0
2 00001010 2 deadbeef 00000000 1
1 80000010 2 00000000 00000000 1
1 00000810 2 00000000 33333333 0

/* verif/ahb_mem_tb.sv */
// Bus-master testbench for the on-chip memory subsystem
// Transfers and expected responses come from verif/ahb_mem_cases.txt
// Run from the project root so the case file path resolves
// Next address overlaps the current data phase, held while hready_o is low
`timescale 1ns/1ps
`include "ahb_mem_cfg.svh"

module ahb_mem_tb
	import ahb_mem_pkg::*;
();

	localparam int MAX_CASES = 64;
	localparam int NCOLS     = 6;       // Values per case line

	// Case file columns
	localparam int COL_OP    = 0;
	localparam int COL_ADDR  = 1;
	localparam int COL_SIZE  = 2;
	localparam int COL_WDATA = 3;
	localparam int COL_RDATA = 4;
	localparam int COL_RESP  = 5;

	// Transfer kinds in the op column
	localparam logic [31:0] OP_IDLE  = 32'd0;
	localparam logic [31:0] OP_READ  = 32'd1;
	localparam logic [31:0] OP_WRITE = 32'd2;

	logic    fclk;
	logic    fpga_reset_n;
	haddr_t  haddr;
	htrans_t htrans;
	hsize_t  hsize;
	logic    hwrite;
	hdata_t  hwdata;
	hdata_t  hrdata;
	logic    hready;
	logic    hresp;

	logic [31:0] case_mem [MAX_CASES*NCOLS];   // Flat, NCOLS words per case
	int          num_cases   = 0;
	int          cycle_limit = 0;
	int          cycle_cnt   = 0;
	int          errors      = 0;
	int          checks      = 0;

	ahb_mem_top ahb_mem_inst (
		.fclk         (fclk),
		.fpga_reset_n (fpga_reset_n),
		.haddr_i      (haddr),
		.htrans_i     (htrans),
		.hsize_i      (hsize),
		.hwrite_i     (hwrite),
		.hwdata_i     (hwdata),
		.hrdata_o     (hrdata),
		.hready_o     (hready),
		.hresp_o      (hresp)
	);

	// 8 ns clock
	initial begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	// ------------------------------------------------------------
	// Run limit
	// ------------------------------------------------------------
	initial begin : watchdog
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge fclk);
			cycle_cnt++;
		end
		errors++;
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("checks %0d, errors %0d", checks, errors);
		$display("ERRORS FOUND");
		$finish;
	end

	// Count every compare, report the failing ones
	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp, input string where);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("mismatch %s at %s: got %h, expected %h", name, where, got, exp);
		end
	endtask

	task automatic load_cases();
		num_cases = 0;
		$readmemh("verif/ahb_mem_cases.txt", case_mem);
		// Unloaded entries stay unknown, first one ends the list
		while (num_cases < MAX_CASES && !$isunknown(case_mem[num_cases*NCOLS]))
			num_cases++;
		if (num_cases == 0) begin
			errors++;
			$display("no transfers were read from the case file");
		end
		for (int c = 0; c < num_cases; c++) begin
			if (case_mem[c*NCOLS+COL_OP] > OP_WRITE) begin
				errors++;
				$display("case %0d has an unknown transfer kind", c);
			end
		end
	endtask

	// Address phase of one case, negative index gives an idle bus
	task automatic present_case(input int c);
		if (c < 0) begin
			haddr  <= '0;
			htrans <= `HTRANS_IDLE;
			hsize  <= `HSIZE_WORD;
			hwrite <= 1'b0;
		end else begin
			haddr  <= case_mem[c*NCOLS+COL_ADDR];
			htrans <= (case_mem[c*NCOLS+COL_OP] == OP_IDLE) ? `HTRANS_IDLE : `HTRANS_NONSEQ;
			hsize  <= hsize_t'(case_mem[c*NCOLS+COL_SIZE]);
			hwrite <= (case_mem[c*NCOLS+COL_OP] == OP_WRITE);
		end
	endtask

	// One data-phase cycle, cyc counts cycles since the phase began
	task automatic check_phase(input int c, input int cyc);
		logic  exp_rdy;
		logic  exp_resp;
		string where;
		if (c < 0) begin
			exp_rdy  = 1'b1;     // Nothing in flight
			exp_resp = 1'b0;
			where    = "idle bus";
		end else begin
			exp_resp = case_mem[c*NCOLS+COL_RESP][0];
			exp_rdy  = !(exp_resp && cyc == 0);     // ERROR waits one cycle
			where    = $sformatf("case %0d", c);
		end
		check_val("hready_o", 32'(hready), 32'(exp_rdy), where);
		check_val("hresp_o", 32'(hresp), 32'(exp_resp), where);
		if (c >= 0 && exp_rdy && case_mem[c*NCOLS+COL_OP] == OP_READ)
			check_val("hrdata_o", hrdata, case_mem[c*NCOLS+COL_RDATA], where);
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin : main_seq
		int   next_case;
		int   addr_case;    // Case in the address phase
		int   dp_case;      // Case in the data phase
		int   err_cyc;
		logic rdy;          // hready_o seen before the coming edge
		bit   done;

		fpga_reset_n = 1'b0;
		haddr        = '0;
		htrans       = `HTRANS_IDLE;
		hsize        = `HSIZE_WORD;
		hwrite       = 1'b0;
		hwdata       = '0;

		load_cases();
		cycle_limit = 16 + 6 * num_cases + 50;

		repeat (16) @(posedge fclk);
		fpga_reset_n <= 1'b1;

		// Quiet bus right after reset
		@(negedge fclk);
		check_val("hready_o", 32'(hready), 32'd1, "reset exit");
		check_val("hresp_o", 32'(hresp), 32'd0, "reset exit");

		next_case = 0;
		addr_case = -1;
		dp_case   = -1;
		err_cyc   = 0;
		rdy       = hready;
		done      = (num_cases == 0);
		while (!done) begin
			@(posedge fclk);
			if (rdy) begin
				dp_case = addr_case;     // Address accepted at this edge
				err_cyc = 0;
				if (next_case < num_cases) begin
					addr_case = next_case;
					next_case++;
				end else begin
					addr_case = -1;
				end
				present_case(addr_case);
				if (dp_case >= 0)
					hwdata <= case_mem[dp_case*NCOLS+COL_WDATA];
				else
					hwdata <= '0;
			end
			// Outputs settle well before the falling edge
			@(negedge fclk);
			check_phase(dp_case, err_cyc);
			err_cyc++;
			rdy  = hready;
			done = (next_case >= num_cases) && (addr_case < 0) && (dp_case < 0);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* logic/ahb_mem_top.sv */
// On-chip memory subsystem behind one AHB-Lite slave port
// NUM_BANKS identical SRAM banks plus a default slave for the rest
// Board reset comes straight in, no local sequencing
`timescale 1ns/1ps
`include "ahb_mem_cfg.svh"

module ahb_mem_top
	import ahb_mem_pkg::*;
(
	input  logic    fclk,
	input  logic    fpga_reset_n,
	input  haddr_t  haddr_i,
	input  htrans_t htrans_i,
	input  hsize_t  hsize_i,
	input  logic    hwrite_i,
	input  hdata_t  hwdata_i,
	output hdata_t  hrdata_o,
	output logic    hready_o,
	output logic    hresp_o
);

	ahb_req_if   req ();
	ahb_slave_if sif [`NUM_SLAVES] ();    // Last entry is the default slave

	// Request group from the port
	assign req.haddr  = haddr_i;
	assign req.htrans = htrans_i;
	assign req.hsize  = hsize_i;
	assign req.hwrite = hwrite_i;
	assign req.hwdata = hwdata_i;

	ahb_addr_decode u_addr_decode (
		.req (req),
		.sel (sif)
	);

	// ---------------------------------------------------------
	// Boot, code and data banks
	// ---------------------------------------------------------
	for (genvar k = 0; k < `NUM_BANKS; k++) begin : g_bank
		ahb_sram_bank u_bank (
			.fclk         (fclk),
			.fpga_reset_n (fpga_reset_n),
			.req          (req),
			.sif          (sif[k])
		);
	end

	ahb_default_slave u_default_slave (
		.fclk         (fclk),
		.fpga_reset_n (fpga_reset_n),
		.req          (req),
		.sif          (sif[`NUM_BANKS])
	);

	ahb_slave_mux u_slave_mux (
		.fclk         (fclk),
		.fpga_reset_n (fpga_reset_n),
		.req          (req),        // Drives the bus hready
		.sif          (sif),
		.hrdata_o     (hrdata_o),
		.hready_o     (hready_o),
		.hresp_o      (hresp_o)
	);

endmodule

/* logic/ahb_slave_mux.sv */
// Response multiplexer back to the bus master
// Select is registered on every ready edge, so it tracks the data phase
// No data-phase owner gives ready, OKAY and zero read data
`timescale 1ns/1ps
`include "ahb_mem_cfg.svh"

module ahb_slave_mux
	import ahb_mem_pkg::*;
(
	input  logic     fclk,
	input  logic     fpga_reset_n,
	ahb_req_if.mux   req,
	ahb_slave_if.mux sif [`NUM_SLAVES],
	output hdata_t   hrdata_o,
	output logic     hready_o,
	output logic     hresp_o
);

	slave_sel_t              addr_sel;   // Address phase selects
	slave_sel_t              dp_sel;     // Data phase owner
	logic [`NUM_SLAVES-1:0]  ready_v;
	logic [`NUM_SLAVES-1:0]  resp_v;
	hdata_t                  rdata_v [`NUM_SLAVES];
	hdata_t                  rdata_mux;
	logic                    ready_mux;
	logic                    resp_mux;

	// Gather the slave group into plain vectors
	for (genvar k = 0; k < `NUM_SLAVES; k++) begin : g_gather
		assign addr_sel[k] = sif[k].hsel;
		assign ready_v[k]  = sif[k].hreadyout;
		assign resp_v[k]   = sif[k].hresp;
		assign rdata_v[k]  = sif[k].hrdata;
	end

	// Data phase select, held through wait states
	always_ff @(posedge fclk or negedge fpga_reset_n) begin
		if (!fpga_reset_n)
			dp_sel <= '0;
		else if (ready_mux)
			dp_sel <= addr_sel;
	end

	// ---------------------------------------------------------
	// Response routing
	// ---------------------------------------------------------
	always_comb begin
		rdata_mux = '0;
		ready_mux = 1'b1;     // Idle bus
		resp_mux  = 1'b0;
		for (int k = 0; k < `NUM_SLAVES; k++) begin
			if (dp_sel[k]) begin
				rdata_mux = rdata_v[k];
				ready_mux = ready_v[k];
				resp_mux  = resp_v[k];
			end
		end
	end

	assign req.hready = ready_mux;     // Fed back to all slaves
	assign hready_o   = ready_mux;
	assign hresp_o    = resp_mux;
	assign hrdata_o   = rdata_mux;

	// Decoder one-hot survives into the data phase, zero only after reset
	a_dp_sel: assert property (@(posedge fclk) disable iff (!fpga_reset_n)
		$onehot0(dp_sel))
		else $error("mux: mismatch dp_sel %h not one-hot", dp_sel);

endmodule

/* logic/ahb_default_slave.sv */
// Error responder for unmapped addresses
// Active transfers get the two-cycle ERROR while IDLE and BUSY get OKAY
// Read data is always zero
`timescale 1ns/1ps
`include "ahb_mem_cfg.svh"

module ahb_default_slave
	import ahb_mem_pkg::*;
(
	input  logic       fclk,
	input  logic       fpga_reset_n,
	ahb_req_if.slave   req,
	ahb_slave_if.slave sif
);

	def_state_t state;
	logic       active;     // NONSEQ or SEQ
	logic       err_start;  // Accepted transfer to an unmapped address

	always_comb begin
		case (req.htrans)
			`HTRANS_NONSEQ, `HTRANS_SEQ: active = 1'b1;
			`HTRANS_IDLE, `HTRANS_BUSY:  active = 1'b0;
			default:                     active = 1'b0;
		endcase
	end

	assign err_start = sif.hsel & req.hready & active;

	always_ff @(posedge fclk or negedge fpga_reset_n) begin
		if (!fpga_reset_n) begin
			state <= IDLE_OK;
		end else begin
			case (state)
				IDLE_OK:    state <= err_start ? ERR_FIRST : IDLE_OK;
				ERR_FIRST:  state <= ERR_SECOND;    // Bus is held with no new address
				ERR_SECOND: state <= err_start ? ERR_FIRST : IDLE_OK;
				default:    state <= IDLE_OK;
			endcase
		end
	end

	// Low ready only in the first ERROR cycle
	assign sif.hreadyout = (state != ERR_FIRST);
	assign sif.hresp     = (state != IDLE_OK);
	assign sif.hrdata    = '0;

	// First ERROR cycle must stall the bus through the mux
	a_err_pair: assert property (@(posedge fclk) disable iff (!fpga_reset_n)
		(state == ERR_FIRST) |-> !req.hready)
		else $error("default slave: mismatch hready %h in first ERROR cycle", req.hready);

endmodule

/* logic/ahb_sram_bank.sv */
// Zero-wait AHB-Lite to SRAM bridge with its own memory array
// Writes wait in a one-entry buffer until the next write arrives
// Reads merge buffered bytes of the same word over the array
// Array read is combinational on the registered word address
// Little-endian and never returns ERROR
`timescale 1ns/1ps
`include "ahb_mem_cfg.svh"

module ahb_sram_bank
	import ahb_mem_pkg::*;
(
	input  logic       fclk,
	input  logic       fpga_reset_n,
	ahb_req_if.slave   req,
	ahb_slave_if.slave sif
);

	localparam int WORD_AW = `BANK_AW - 2;     // Word address bits
	localparam int DEPTH   = 1 << WORD_AW;      // Words per bank
	localparam int NLANES  = `AHB_DW / 8;

	hdata_t             mem [DEPTH];    // Memory array

	logic               sel_active;     // Accepted address phase here
	logic               wr_dp;          // Write data phase ends this edge
	logic               ph_write;
	logic [WORD_AW-1:0] ph_addr;
	byte_en_t           ph_lanes;
	logic               buf_valid;
	logic [WORD_AW-1:0] buf_addr;
	byte_en_t           buf_lanes;
	hdata_t             buf_data;
	logic               buf_hit;
	hdata_t             rd_array;
	hdata_t             rd_merge;

	// Byte lanes touched by one transfer
	function automatic byte_en_t lanes_of(input hsize_t size, input logic [1:0] low);
		byte_en_t lanes;
		case (size)
			`HSIZE_BYTE: lanes = byte_en_t'(4'b0001 << low);
			`HSIZE_HALF: lanes = low[1] ? 4'b1100 : 4'b0011;
			`HSIZE_WORD: lanes = 4'b1111;
			default:     lanes = 4'b0000;       // Wider than the bus
		endcase
		return lanes;
	endfunction

	// ---------------------------------------------------------
	// Address phase
	// ---------------------------------------------------------
	assign sel_active = sif.hsel & req.hready &
		((req.htrans == `HTRANS_NONSEQ) | (req.htrans == `HTRANS_SEQ));

	always_ff @(posedge fclk or negedge fpga_reset_n) begin
		if (!fpga_reset_n)
			ph_write <= 1'b0;
		else if (req.hready)
			ph_write <= sel_active & req.hwrite;
	end

	always_ff @(posedge fclk) begin
		if (sel_active) begin
			ph_addr  <= req.haddr[`BANK_AW-1:2];
			ph_lanes <= lanes_of(req.hsize, req.haddr[1:0]);
		end
	end

	// Zero-wait means the data phase ends on the next ready edge
	assign wr_dp = ph_write & req.hready;

	// ---------------------------------------------------------
	// Write buffer
	// ---------------------------------------------------------
	always_ff @(posedge fclk or negedge fpga_reset_n) begin
		if (!fpga_reset_n)
			buf_valid <= 1'b0;
		else if (wr_dp)
			buf_valid <= 1'b1;      // Stays full from the first write on
	end

	always_ff @(posedge fclk) begin
		if (wr_dp) begin
			buf_addr  <= ph_addr;
			buf_lanes <= ph_lanes;
			buf_data  <= req.hwdata;    // hwdata belongs to the data phase
		end
	end

	// Older entry goes to the array as the new one is captured
	always_ff @(posedge fclk) begin
		if (wr_dp && buf_valid) begin
			for (int i = 0; i < NLANES; i++) begin
				if (buf_lanes[i])
					mem[buf_addr][8*i +: 8] <= buf_data[8*i +: 8];
			end
		end
	end

	// ---------------------------------------------------------
	// Read data
	// ---------------------------------------------------------
	assign rd_array = mem[ph_addr];
	assign buf_hit  = buf_valid & (buf_addr == ph_addr);

	// Buffered lanes win over stale array bytes
	always_comb begin
		for (int i = 0; i < NLANES; i++) begin
			if (buf_hit && buf_lanes[i])
				rd_merge[8*i +: 8] = buf_data[8*i +: 8];
			else
				rd_merge[8*i +: 8] = rd_array[8*i +: 8];
		end
	end

	assign sif.hrdata    = rd_merge;
	assign sif.hreadyout = 1'b1;    // Never inserts wait states
	assign sif.hresp     = 1'b0;

	// Oversized write reaches its data phase with no lanes and is lost
	a_wr_size: assert property (@(posedge fclk) disable iff (!fpga_reset_n)
		wr_dp |-> (ph_lanes != '0))
		else $error("bank: write data phase with size above word");

endmodule

/* logic/ahb_addr_decode.sv */
// Address decode into one-hot slave selects
// Banks sit back to back from address zero, everything else errors
// Purely combinational, select is valid in the address phase only
`timescale 1ns/1ps
`include "ahb_mem_cfg.svh"

module ahb_addr_decode
	import ahb_mem_pkg::*;
(
	ahb_req_if.slave    req,
	ahb_slave_if.decode sel [`NUM_SLAVES]
);

	// Bank index field just above the bank region
	localparam int IDX_W = (`NUM_BANKS > 1) ? $clog2(`NUM_BANKS) : 1;

	logic [IDX_W-1:0] bank_idx;
	logic             upper_zero;   // No bits set above the index field
	slave_sel_t       sel_vec;
	slave_sel_t       hsel_chk;     // Selects read back from the array

	assign bank_idx   = req.haddr[`BANK_AW +: IDX_W];
	assign upper_zero = (req.haddr[`AHB_AW-1:`BANK_AW+IDX_W] == '0);

	always_comb begin
		sel_vec = '0;
		if (upper_zero && (bank_idx < `NUM_BANKS))
			sel_vec[bank_idx] = 1'b1;
		else
			sel_vec[`NUM_BANKS] = 1'b1;     // Unmapped, default slave
	end

	for (genvar k = 0; k < `NUM_SLAVES; k++) begin : g_sel
		assign sel[k].hsel = sel_vec[k];
		assign hsel_chk[k] = sel[k].hsel;
	end

	// Exactly one slave owns every address
	always_comb begin
		assert final ($onehot(hsel_chk))
			else $error("decode: selects not one-hot, hsel %h", hsel_chk);
	end

endmodule

/* logic/ahb_slave_if.sv */
// AHB-Lite request group and one slave's select/response group
// hready is the bus ready driven back by the slave mux
`timescale 1ns/1ps
`include "ahb_mem_cfg.svh"

// Request side, seen by every slave
interface ahb_req_if;
	logic [`AHB_AW-1:0] haddr;
	logic [1:0]         htrans;
	logic [2:0]         hsize;
	logic               hwrite;
	logic [`AHB_DW-1:0] hwdata;     // Data phase only
	logic               hready;     // From mux

	modport master (output haddr, htrans, hsize, hwrite, hwdata, input hready);
	modport slave  (input haddr, htrans, hsize, hwrite, hwdata, hready);
	modport mux    (output hready);
endinterface

// Select and response of one slave
interface ahb_slave_if;
	logic               hsel;       // Address phase select
	logic               hreadyout;
	logic               hresp;      // 1 = ERROR
	logic [`AHB_DW-1:0] hrdata;

	modport decode (output hsel);
	modport slave  (input hsel, output hreadyout, hresp, hrdata);
	modport mux    (input hsel, hreadyout, hresp, hrdata);
endinterface

/* logic/ahb_mem_pkg.sv */
// Bus types for the memory subsystem
// Widths follow the cfg header, so edit sizes there only
`include "ahb_mem_cfg.svh"

package ahb_mem_pkg;

	// ---------------------------------------------------------
	// Bus fields
	// ---------------------------------------------------------
	typedef logic [`AHB_AW-1:0]     haddr_t;      // Bus address
	typedef logic [`AHB_DW-1:0]     hdata_t;      // Read or write word
	typedef logic [1:0]             htrans_t;     // Transfer type
	typedef logic [2:0]             hsize_t;      // Transfer size
	typedef logic [`AHB_DW/8-1:0]   byte_en_t;    // One bit per byte lane

	// One-hot select, index NUM_BANKS is the default slave
	typedef logic [`NUM_SLAVES-1:0] slave_sel_t;

	// Default slave FSM
	typedef enum logic [1:0] {
		IDLE_OK,        // Zero-wait OKAY
		ERR_FIRST,      // Wait state, ERROR
		ERR_SECOND      // Ready, ERROR
	} def_state_t;

endpackage

/* logic/ahb_mem_cfg.svh */
// Bus widths, bank geometry and AHB-Lite encodings
// All banks share one size; NUM_SLAVES counts the default slave too
`ifndef AHB_MEM_CFG_SVH
`define AHB_MEM_CFG_SVH

`define AHB_AW          32          // System address width
`define AHB_DW          32          // Data width, four byte lanes
`define BANK_AW         10          // Byte address bits per bank, 1 KB
`define NUM_BANKS       3           // Boot, code, data
`define NUM_SLAVES      (`NUM_BANKS + 1)

// HTRANS codes
`define HTRANS_IDLE     2'b00
`define HTRANS_BUSY     2'b01
`define HTRANS_NONSEQ   2'b10
`define HTRANS_SEQ      2'b11

// HSIZE codes, nothing wider than the bus
`define HSIZE_BYTE      3'b000
`define HSIZE_HALF      3'b001
`define HSIZE_WORD      3'b010

`endif
